/* sim.f */
hw/jalr_pkg.sv
hw/gpr_file.sv
hw/raw_scoreboard.sv
hw/gpr_rd_arbiter.sv
hw/jalr_baseaddr_rd.sv
hw/decode_operand_rd.sv
hw/jalr_fetch_top.sv
verification/jalr_fetch_properties.sv
verification/jalr_fetch_tb.sv

/* Bender.yml */
package:
  name: jalr_fetch

sources:
  - files:
      - hw/jalr_pkg.sv
      - hw/gpr_file.sv
      - hw/raw_scoreboard.sv
      - hw/gpr_rd_arbiter.sv
      - hw/jalr_baseaddr_rd.sv
      - hw/decode_operand_rd.sv
      - hw/jalr_fetch_top.sv
  - target: simulation
    files:
      - verification/jalr_fetch_properties.sv
      - verification/jalr_fetch_tb.sv

/* verification/jalr_fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module jalr_fetch_tb;

	localparam int n_steps = 3000; // stimulus cycles before the drain
	localparam int cycle_limit = n_steps * 4 + 100; // timeout in cycles
	localparam int idx_bits = 3; // x0..x7 only, more hazards and contention

	logic clk, resetn, flush, dec_vld, issue_vld, operand_vld;
	logic [jalr_pkg::reg_id_w-1:0] dec_rs, issue_rd, dbg_addr;
	logic [jalr_pkg::xlen-1:0] operand, dbg_data;
	jalr_pkg::fetch_inst_t inst;
	jalr_pkg::wb_t wb;
	jalr_pkg::base_rsp_t base;

	logic [jalr_pkg::xlen-1:0] m_regs [jalr_pkg::nreg]; // model register bank
	logic [jalr_pkg::nreg-1:0] m_pend; // model pending writes
	jalr_pkg::rd_owner_e m_last; // model last port 0 winner
	logic j_busy, d_busy; // jalr and decode request open
	logic [15:0] lfsr;
	int cycles, err_base, err_word, err_owner;

	jalr_fetch_top uut (.*);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#10 clk = ~clk; // 20 ns period
		end
	end

	initial
	begin
		cycles = 0;
		while (cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, a request never completed", cycles);
		$display("error counts: base %0d, operand %0d, owner %0d", err_base, err_word, err_owner);
		$display("Done: errors found");
		$finish;
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_base(input jalr_pkg::base_rsp_t got, input jalr_pkg::base_rsp_t exp);
		if (got.vld !== exp.vld || (exp.vld && got.addr !== exp.addr))
		begin
			err_base++;
			$display("[ERROR] %0t: base got vld=%b addr=%h, expected vld=%b addr=%h",
				$time, got.vld, got.addr, exp.vld, exp.addr);
		end
	endtask

	task automatic check_word(input string what, input logic got_vld,
		input logic [jalr_pkg::xlen-1:0] got, input logic exp_vld,
		input logic [jalr_pkg::xlen-1:0] exp);
		if (got_vld !== exp_vld || (exp_vld && got !== exp))
		begin
			err_word++;
			$display("[ERROR] %0t: %s got vld=%b data=%h, expected vld=%b data=%h",
				$time, what, got_vld, got, exp_vld, exp);
		end
	endtask

	task automatic check_owner(input jalr_pkg::rd_owner_e got, input jalr_pkg::rd_owner_e exp);
		if (got !== exp)
		begin
			err_owner++;
			$display("[ERROR] %0t: port 0 went to %s, expected %s", $time, got.name(), exp.name());
		end
	endtask

	// drive at the falling edge, check before the rising edge, then step the model
	task automatic run_cycle(input logic allow_new);
		logic [31:0] r;
		jalr_pkg::base_src_e j_src;
		logic j_act, d_act, d_zero, j_req, d_req, j_win, d_win, exp_op_vld, j_seen;
		logic [jalr_pkg::xlen-1:0] exp_op, exp_dbg;
		jalr_pkg::base_rsp_t exp_base;
		@(negedge clk);
		inst.vld = 1'b0; // strobes last one cycle
		dec_vld = 1'b0;
		take_bits(5, r);
		flush = (r[4:0] == 0); // about 1 in 32
		if (allow_new && !flush && !j_busy)
		begin
			take_bits(3, r);
			if (r[0])
			begin
				take_bits(idx_bits, r);
				inst.vld = 1'b1;
				inst.is_jalr = (r[2:1] != 0); // a quarter are other instructions
				inst.rs1 = r[jalr_pkg::reg_id_w-1:0];
				j_busy = inst.is_jalr; // rs1 stays steady until base valid
			end
		end
		if (allow_new && !flush && !d_busy)
		begin
			take_bits(1, r);
			if (r[0])
			begin
				take_bits(idx_bits, r);
				dec_vld = 1'b1;
				dec_rs = r[jalr_pkg::reg_id_w-1:0];
				d_busy = 1'b1;
			end
		end
		take_bits(2, r);
		issue_vld = allow_new && (r[1:0] == 0); // no issues in the drain
		take_bits(idx_bits, r);
		issue_rd = r[jalr_pkg::reg_id_w-1:0];
		take_bits(1, r);
		wb.vld = r[0];
		take_bits(idx_bits, r);
		wb.rd = r[jalr_pkg::reg_id_w-1:0]; // x0 included
		take_bits(jalr_pkg::xlen, r);
		wb.data = r;
		take_bits(idx_bits, r);
		dbg_addr = r[jalr_pkg::reg_id_w-1:0];
		#5; // settled, rising edge 5 ns away
		if (inst.rs1 == jalr_pkg::reg_x0)
			j_src = jalr_pkg::src_zero;
		else if (inst.rs1 == jalr_pkg::reg_x1)
			j_src = jalr_pkg::src_x1;
		else
			j_src = jalr_pkg::src_port0;
		j_act = !flush && j_busy;
		d_act = !flush && d_busy;
		d_zero = (dec_rs == jalr_pkg::reg_x0);
		j_req = j_act && (j_src == jalr_pkg::src_port0) && !m_pend[inst.rs1];
		d_req = d_act && !d_zero && !m_pend[dec_rs];
		j_win = j_req && (!d_req || (m_last == jalr_pkg::owner_dec)); // other one from last time
		d_win = d_req && !j_win;
		exp_base = '0;
		case (j_src)
			jalr_pkg::src_zero: exp_base.vld = j_act; // same cycle, zero
			jalr_pkg::src_x1:
			begin
				exp_base.vld = j_act && !m_pend[jalr_pkg::reg_x1]; // waits for x1 writeback
				exp_base.addr = m_regs[jalr_pkg::reg_x1];
			end
			default:
			begin
				exp_base.vld = j_win; // base with the grant
				exp_base.addr = m_regs[inst.rs1];
			end
		endcase
		exp_op_vld = d_act && (d_zero || d_win);
		exp_op = d_zero ? '0 : m_regs[dec_rs];
		exp_dbg = (dbg_addr == jalr_pkg::reg_x0) ? '0 : m_regs[dbg_addr]; // x0 always zero
		check_base(base, exp_base);
		check_word("operand", operand_vld, operand, exp_op_vld, exp_op);
		check_word("debug read", 1'b1, dbg_data, 1'b1, exp_dbg);
		j_seen = base.vld && (j_src == jalr_pkg::src_port0); // jalr took port 0
		if (j_seen || (operand_vld && !d_zero))
			check_owner(j_seen ? jalr_pkg::owner_jalr : jalr_pkg::owner_dec,
				j_win ? jalr_pkg::owner_jalr : jalr_pkg::owner_dec);
		if (flush || exp_base.vld)
			j_busy = 1'b0; // done or abandoned
		if (flush || exp_op_vld)
			d_busy = 1'b0;
		if (j_win)
			m_last = jalr_pkg::owner_jalr;
		else if (d_win)
			m_last = jalr_pkg::owner_dec;
		if (wb.vld)
			m_pend[wb.rd] = 1'b0;
		if (wb.vld && wb.rd != jalr_pkg::reg_x0)
			m_regs[wb.rd] = wb.data;
		if (issue_vld && issue_rd != jalr_pkg::reg_x0)
			m_pend[issue_rd] = 1'b1; // issue wins over writeback
	endtask

	initial
	begin
		resetn = 1'b0;
		flush = 1'b0;
		inst = '0;
		dec_vld = 1'b0;
		dec_rs = '0;
		issue_vld = 1'b0;
		issue_rd = '0;
		wb = '0;
		dbg_addr = '0;
		lfsr = 16'd86; // seed
		err_base = 0;
		err_word = 0;
		err_owner = 0;
		j_busy = 1'b0;
		d_busy = 1'b0;
		m_pend = '0;
		m_last = jalr_pkg::owner_dec; // reset value of the arbiter
		for (int i = 0; i < jalr_pkg::nreg; i++)
			m_regs[i] = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;
		for (int step = 0; step < n_steps; step++)
			run_cycle(1'b1);
		while (j_busy || d_busy)
			run_cycle(1'b0); // drain open requests
		$display("error counts: base %0d, operand %0d, owner %0d", err_base, err_word, err_owner);
		if (err_base + err_word + err_owner == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* verification/jalr_fetch_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module jalr_fetch_properties
(
	input wire logic clk,
	input wire logic resetn,
	input jalr_pkg::rd_port_req_t jalr_req,
	input jalr_pkg::rd_port_req_t dec_req,
	input jalr_pkg::rd_port_rsp_t jalr_rsp,
	input jalr_pkg::rd_port_rsp_t dec_rsp
);

	jalr_pkg::rd_owner_e prev_win; // last winner, seen from the grants only

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			prev_win <= jalr_pkg::owner_dec;
		end
		else if (jalr_rsp.grant)
		begin
			prev_win <= jalr_pkg::owner_jalr;
		end
		else if (dec_rsp.grant)
		begin
			prev_win <= jalr_pkg::owner_dec;
		end
	end

	a_one_grant: assert property (@(posedge clk) disable iff (!resetn)
		!(jalr_rsp.grant && dec_rsp.grant)) // one owner per cycle
		else $error("both port 0 grants high in one cycle");

	a_grant_req: assert property (@(posedge clk) disable iff (!resetn)
		(!jalr_rsp.grant || jalr_req.req) && (!dec_rsp.grant || dec_req.req))
		else $error("port 0 grant given without a request");

	// contention goes to the one that lost last time
	a_round_robin: assert property (@(posedge clk) disable iff (!resetn)
		(jalr_req.req && dec_req.req) |->
		((prev_win == jalr_pkg::owner_dec) ? jalr_rsp.grant : dec_rsp.grant))
		else $error("round robin order broken under contention");

endmodule

bind gpr_rd_arbiter jalr_fetch_properties u_props (
	.clk(clk),
	.resetn(resetn),
	.jalr_req(jalr_req),
	.dec_req(dec_req),
	.jalr_rsp(jalr_rsp),
	.dec_rsp(dec_rsp)
);

`default_nettype wire

/* hw/jalr_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module jalr_fetch_top
(
	input wire logic clk,
	input wire logic resetn,
	input wire logic flush, // to both port 0 users

	input jalr_pkg::fetch_inst_t inst, // fetch output

	// decode operand request
	input wire logic dec_vld,
	input wire logic [jalr_pkg::reg_id_w-1:0] dec_rs,

	// scoreboard issue
	input wire logic issue_vld,
	input wire logic [jalr_pkg::reg_id_w-1:0] issue_rd,

	input jalr_pkg::wb_t wb, // writeback

	output jalr_pkg::base_rsp_t base, // jalr base address
	output logic operand_vld,
	output logic [jalr_pkg::xlen-1:0] operand,

	// debug read through read port 1
	input wire logic [jalr_pkg::reg_id_w-1:0] dbg_addr,
	output logic [jalr_pkg::xlen-1:0] dbg_data
);

	jalr_pkg::rd_port_req_t jalr_req; // jalr to arbiter
	jalr_pkg::rd_port_req_t dec_req; // decode to arbiter
	jalr_pkg::rd_port_rsp_t jalr_rsp;
	jalr_pkg::rd_port_rsp_t dec_rsp;
	logic [jalr_pkg::reg_id_w-1:0] port_addr; // arbitrated port 0 address
	logic [jalr_pkg::xlen-1:0] port_data;
	logic [jalr_pkg::xlen-1:0] x1_v; // x1 tap
	logic jalr_raw; // hazard on jalr rs1
	logic dec_raw; // hazard on decode source

	gpr_file u_gpr (
		.clk(clk),
		.resetn(resetn),
		.rd0_addr(port_addr),
		.rd0_data(port_data),
		.rd1_addr(dbg_addr),
		.rd1_data(dbg_data),
		.x1_v(x1_v),
		.wb(wb)
	);

	raw_scoreboard u_sb (
		.clk(clk),
		.resetn(resetn),
		.issue_vld(issue_vld),
		.issue_rd(issue_rd),
		.wb(wb),
		.jalr_rs1(inst.rs1),
		.dec_rs(dec_rs),
		.jalr_raw(jalr_raw),
		.dec_raw(dec_raw)
	);

	gpr_rd_arbiter u_arb (
		.clk(clk),
		.resetn(resetn),
		.jalr_req(jalr_req),
		.dec_req(dec_req),
		.jalr_rsp(jalr_rsp),
		.dec_rsp(dec_rsp),
		.port_addr(port_addr),
		.port_data(port_data)
	);

	jalr_baseaddr_rd u_jalr (
		.clk(clk),
		.resetn(resetn),
		.flush(flush),
		.inst(inst),
		.rs1_raw(jalr_raw),
		.x1_v(x1_v),
		.port_req(jalr_req),
		.port_rsp(jalr_rsp),
		.base(base)
	);

	decode_operand_rd u_dec (
		.clk(clk),
		.resetn(resetn),
		.flush(flush),
		.dec_vld(dec_vld),
		.dec_rs(dec_rs),
		.rs_raw(dec_raw),
		.port_req(dec_req),
		.port_rsp(dec_rsp),
		.operand_vld(operand_vld),
		.operand(operand)
	);

endmodule

`default_nettype wire

/* hw/decode_operand_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_operand_rd
(
	input wire logic clk,
	input wire logic resetn,

	input wire logic flush, // drop pending read

	input wire logic dec_vld, // decode strobe
	input wire logic [jalr_pkg::reg_id_w-1:0] dec_rs, // source index, steady while held
	input wire logic rs_raw, // source has a pending write

	output jalr_pkg::rd_port_req_t port_req, // read port 0 request
	input jalr_pkg::rd_port_rsp_t port_rsp,

	output logic operand_vld, // operand ready
	output logic [jalr_pkg::xlen-1:0] operand
);

	logic rs_zero; // source is x0
	logic rd_hold; // read still open
	logic active; // read being served this cycle

	assign rs_zero = (dec_rs == jalr_pkg::reg_x0);
	assign active = !flush && (dec_vld || rd_hold);

	// x0 needs no port access
	assign port_req.req = active && !rs_zero && !rs_raw;
	assign port_req.addr = dec_rs;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			rd_hold <= 1'b0;
		end
		else
		begin
			// open from the strobe until grant, raw just delays the request
			rd_hold <= !flush && (rd_hold || (dec_vld && !rs_zero)) && !port_rsp.grant;
		end
	end

	assign operand_vld = active && (rs_zero || port_rsp.grant); // x0 done at once
	assign operand = rs_zero ? '0 : port_rsp.data;

endmodule

`default_nettype wire

/* hw/jalr_baseaddr_rd.sv */
`timescale 1ns/1ps
`default_nettype none

module jalr_baseaddr_rd
(
	input wire logic clk,
	input wire logic resetn,

	input wire logic flush, // abandon current jalr

	input jalr_pkg::fetch_inst_t inst, // from fetch, steady while held
	input wire logic rs1_raw, // rs1 has a pending write
	input wire logic [jalr_pkg::xlen-1:0] x1_v, // x1 tap

	output jalr_pkg::rd_port_req_t port_req, // read port 0 request
	input jalr_pkg::rd_port_rsp_t port_rsp,

	output jalr_pkg::base_rsp_t base // base address result
);

	jalr_pkg::base_src_e src; // where rs1 is read from
	logic need_p0; // jalr needs port 0
	logic need_x1; // jalr needs x1
	logic p0_hold; // port 0 request still open
	logic x1_hold; // x1 waiting for raw to clear
	logic active; // jalr being served this cycle

	always_comb
	begin
		if (inst.rs1 == jalr_pkg::reg_x0)
			src = jalr_pkg::src_zero;
		else if (inst.rs1 == jalr_pkg::reg_x1)
			src = jalr_pkg::src_x1;
		else
			src = jalr_pkg::src_port0;
	end

	assign need_p0 = inst.is_jalr && (src == jalr_pkg::src_port0);
	assign need_x1 = inst.is_jalr && (src == jalr_pkg::src_x1);
	assign active = !flush && (inst.vld || p0_hold || x1_hold);

	// no request while rs1 still has a write in flight
	assign port_req.req = active && need_p0 && !rs1_raw;
	assign port_req.addr = inst.rs1;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			p0_hold <= 1'b0;
			x1_hold <= 1'b0;
		end
		else
		begin
			// stays open until granted
			p0_hold <= !flush && (p0_hold || (inst.vld && need_p0)) && !port_rsp.grant;
			// stays open while x1 is pending
			x1_hold <= !flush && (x1_hold || (inst.vld && need_x1)) && rs1_raw;
		end
	end

	always_comb
	begin
		base.vld = 1'b0;
		base.addr = '0;
		case (src)
			jalr_pkg::src_zero:
			begin
				base.vld = active && inst.is_jalr; // same cycle, zero
			end
			jalr_pkg::src_x1:
			begin
				base.vld = active && inst.is_jalr && !rs1_raw;
				base.addr = x1_v;
			end
			default:
			begin
				base.vld = active && inst.is_jalr && port_rsp.grant; // ends with grant
				base.addr = port_rsp.data;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/gpr_rd_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_rd_arbiter
(
	input wire logic clk,
	input wire logic resetn,

	input jalr_pkg::rd_port_req_t jalr_req, // from jalr base reader
	input jalr_pkg::rd_port_req_t dec_req, // from decode operand reader
	output jalr_pkg::rd_port_rsp_t jalr_rsp,
	output jalr_pkg::rd_port_rsp_t dec_rsp,

	// towards gpr_file read port 0
	output logic [jalr_pkg::reg_id_w-1:0] port_addr,
	input wire logic [jalr_pkg::xlen-1:0] port_data
);

	jalr_pkg::rd_owner_e last_win; // winner of the last granted cycle
	logic jalr_win; // jalr granted now
	logic dec_win; // decode granted now

	// alone wins, on contention the other one from last time wins
	assign jalr_win = jalr_req.req && (!dec_req.req || (last_win == jalr_pkg::owner_dec));
	assign dec_win = dec_req.req && !jalr_win;

	assign port_addr = jalr_win ? jalr_req.addr : dec_req.addr; // mux to port

	assign jalr_rsp.grant = jalr_win;
	assign jalr_rsp.data = port_data; // data shared
	assign dec_rsp.grant = dec_win;
	assign dec_rsp.data = port_data;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			last_win <= jalr_pkg::owner_dec; // jalr favoured first
		end
		else if (jalr_win)
		begin
			last_win <= jalr_pkg::owner_jalr;
		end
		else if (dec_win)
		begin
			last_win <= jalr_pkg::owner_dec;
		end
	end

endmodule

`default_nettype wire

/* hw/raw_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module raw_scoreboard
(
	input wire logic clk,
	input wire logic resetn,

	// issue side sets a pending write
	input wire logic issue_vld,
	input wire logic [jalr_pkg::reg_id_w-1:0] issue_rd,

	input jalr_pkg::wb_t wb, // writeback clears it

	// lookup indices
	input wire logic [jalr_pkg::reg_id_w-1:0] jalr_rs1,
	input wire logic [jalr_pkg::reg_id_w-1:0] dec_rs,

	output logic jalr_raw, // jalr rs1 has a write in flight
	output logic dec_raw // decode source has a write in flight
);

	logic [jalr_pkg::nreg-1:0] pending; // one bit per register
	logic [jalr_pkg::nreg-1:0] pending_nxt;

	always_comb
	begin
		pending_nxt = pending;
		if (wb.vld)
		begin
			pending_nxt[wb.rd] = 1'b0; // writeback done
		end
		// applied after the clear so issue wins on the same index
		if (issue_vld && (issue_rd != jalr_pkg::reg_x0))
		begin
			pending_nxt[issue_rd] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			pending <= '0; // nothing in flight
		end
		else
		begin
			pending <= pending_nxt;
		end
	end

	assign jalr_raw = pending[jalr_rs1];
	assign dec_raw = pending[dec_rs];

endmodule

`default_nettype wire

/* hw/gpr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module gpr_file
(
	input wire logic clk,
	input wire logic resetn,

	// shared read port 0, goes through the arbiter
	input wire logic [jalr_pkg::reg_id_w-1:0] rd0_addr,
	output logic [jalr_pkg::xlen-1:0] rd0_data,

	// second read port, debug read
	input wire logic [jalr_pkg::reg_id_w-1:0] rd1_addr,
	output logic [jalr_pkg::xlen-1:0] rd1_data,

	output logic [jalr_pkg::xlen-1:0] x1_v, // x1 tap for jalr
	input jalr_pkg::wb_t wb // writeback port
);

	logic [jalr_pkg::xlen-1:0] regs [jalr_pkg::nreg]; // register bank
	logic wr_en; // qualified write

	assign wr_en = wb.vld && (wb.rd != jalr_pkg::reg_x0); // x0 never written

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < jalr_pkg::nreg; i++)
			begin
				regs[i] <= '0; // whole bank cleared
			end
		end
		else if (wr_en)
		begin
			regs[wb.rd] <= wb.data;
		end
	end

	// asynchronous reads, x0 reads back zero since it is never written
	assign rd0_data = regs[rd0_addr];
	assign rd1_data = regs[rd1_addr];
	assign x1_v = regs[jalr_pkg::reg_x1]; // stored x1, no bypass

endmodule

`default_nettype wire

/* hw/jalr_pkg.sv */
`default_nettype none

package jalr_pkg;

	localparam int xlen = 32; // data width
	localparam int reg_id_w = 5; // register index width
	localparam int nreg = 32; // rv32 gpr count
	localparam logic [reg_id_w-1:0] reg_x0 = 5'd0; // hardwired zero
	localparam logic [reg_id_w-1:0] reg_x1 = 5'd1; // link register

	// where a jalr base address comes from
	typedef enum logic [1:0]
	{
		src_zero, // rs1 == x0
		src_x1, // dedicated x1 tap
		src_port0 // shared read port 0
	} base_src_e;

	typedef enum logic
	{
		owner_jalr, // jalr base reader
		owner_dec // decode operand reader
	} rd_owner_e;

	typedef struct packed {
		logic vld; // valid instruction strobe
		logic is_jalr; // level, instruction is jalr
		logic [reg_id_w-1:0] rs1; // base register index
	} fetch_inst_t;

	typedef struct packed {
		logic req; // read request
		logic [reg_id_w-1:0] addr; // read address
	} rd_port_req_t;

	typedef struct packed {
		logic grant; // read granted this cycle
		logic [xlen-1:0] data; // port data, shared
	} rd_port_rsp_t;

	typedef struct packed {
		logic vld; // write enable
		logic [reg_id_w-1:0] rd; // destination index
		logic [xlen-1:0] data; // write data
	} wb_t;

	typedef struct packed {
		logic vld; // base address ready
		logic [xlen-1:0] addr; // base address value
	} base_rsp_t;

endpackage

`default_nettype wire
